// ==== Makefile ====
# Verilator build and run for the picc_rx testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= picc_rx_tb
FILELIST  ?= picc_rx.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/picc_rx_checker.sv ====
// picc_rx_checker: concurrent assertions on the strobes of the sequence decoder
module picc_rx_checker (
    input logic pcd_clk,
    input logic pcd_rst_n,
    input logic pause_end,
    input logic bit_valid,
    input logic soc,
    input logic eoc,
    input logic seq_err
);
    timeunit 1ns;
    timeprecision 100ps;

    // failed assertions so far, the testbench reads this at the end of the run
    int   fail_count = 0;
    logic seen_pause_q;

    // goes high on the first pause end after reset and stays there
    always_ff @(posedge pcd_clk or negedge pcd_rst_n) begin
        if (!pcd_rst_n) begin
            seen_pause_q <= 1'b0;
        end else if (pause_end) begin
            seen_pause_q <= 1'b1;
        end
    end

    // ----------------------------------------
    // strobe rules
    // ----------------------------------------

    // an abandoned interval must never deliver a bit at the same time
    no_bit_on_err: assert property (@(posedge pcd_clk) disable iff (!pcd_rst_n)
        !(bit_valid && seq_err))
    else begin
        fail_count++;
        $error("bit strobe together with a sequence error");
    end

    // a frame cannot open and close on the same cycle
    no_soc_with_eoc: assert property (@(posedge pcd_clk) disable iff (!pcd_rst_n)
        !(soc && eoc))
    else begin
        fail_count++;
        $error("start and end of communication high together");
    end

    // nothing may come out of the decoder before the reader has sent a pause
    quiet_until_pause: assert property (@(posedge pcd_clk) disable iff (!pcd_rst_n)
        !seen_pause_q |-> !(bit_valid || soc || eoc || seq_err))
    else begin
        fail_count++;
        $error("decoder strobe before the first pause end");
    end

endmodule

bind sequence_decode picc_rx_checker checker0 (
    .pcd_clk   (pcd_clk),
    .pcd_rst_n (pcd_rst_n),
    .pause_end (pause_end),
    .bit_valid (bit_valid_q),
    .soc       (soc_q),
    .eoc       (eoc_q),
    .seq_err   (seq_err_q)
);

// ==== dv/picc_rx_tb.sv ====
// picc_rx testbench that drives Modified Miller pause frames and checks the received bytes
module picc_rx_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import picc_rx_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 8;
    localparam int RAND_SEED    = 15591;
    localparam int BIT_CYCLES   = 2 * HALF_BIT_TICKS;
    // first pause of a frame starts this many cycles after the frame begins
    localparam int LEAD         = 8;
    // quiet carrier after a frame so that the decoder sees the next SOC
    localparam int IDLE         = 600;

    typedef struct packed {
        logic       is_end;
        logic [7:0] data;
        logic       par_err;
        logic [3:0] residual;
    } event_t;

    logic       pcd_clk = 1'b0;
    logic       pcd_rst_n;
    logic       pcd_pause_n;
    logic [7:0] rx_byte;
    logic       rx_byte_valid;
    logic       rx_parity_err;
    logic       rx_frame_end;
    logic [3:0] rx_last_bits;
    logic       rx_seq_err;

    bit     tx_bits[$];
    event_t exp_q[$];
    int     cur_cycle;
    int     cycle_cnt     = 0;
    int     cycle_limit   = RESET_CYCLES + 1000;
    int     mismatch_count = 0;
    int     other_count    = 0;
    int     exp_seq_err    = 0;
    int     seen_seq_err   = 0;

    picc_rx #(
        .STOP_AFTER_TICKS  (4),
        .START_AFTER_TICKS (10)
    ) dut0 (
        .pcd_clk       (pcd_clk),
        .pcd_rst_n     (pcd_rst_n),
        .pcd_pause_n   (pcd_pause_n),
        .rx_byte       (rx_byte),
        .rx_byte_valid (rx_byte_valid),
        .rx_parity_err (rx_parity_err),
        .rx_frame_end  (rx_frame_end),
        .rx_last_bits  (rx_last_bits),
        .rx_seq_err    (rx_seq_err)
    );

    always #(CLK_PERIOD / 2) pcd_clk = ~pcd_clk;

    // ----------------------------------------
    // reference model and compare tasks
    // ----------------------------------------

    // every nine bits make a byte plus odd parity, leftover bits form the partial byte
    function automatic void expect_frame();
        int         full;
        int         rem;
        logic [8:0] word;
        event_t     ev;
        full = tx_bits.size() / 9;
        for (int k = 0; k < full; k++) begin
            for (int j = 0; j < 9; j++) begin
                word[j] = tx_bits[k * 9 + j];
            end
            ev.is_end   = 1'b0;
            ev.data     = word[7:0];
            // an even count of ones over data and parity is a parity error
            ev.par_err  = ~(^word);
            ev.residual = 4'd0;
            exp_q.push_back(ev);
        end
        rem         = tx_bits.size() - full * 9;
        ev.is_end   = 1'b1;
        ev.data     = 8'h00;
        ev.par_err  = 1'b0;
        ev.residual = 4'(rem);
        for (int j = 0; j < rem; j++) begin
            ev.data[j] = tx_bits[full * 9 + j];
        end
        exp_q.push_back(ev);
    endfunction

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t ns: %s got 0x%02h, expected 0x%02h", $time, what, got, exp);
        end
    endtask

    task automatic check_parity(input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t ns: rx_parity_err got %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic check_residual(input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t ns: rx_last_bits got %0d, expected %0d", $time, got, exp);
        end
    endtask

    // outputs settle after the rising edge, so they are taken at the falling edge
    always @(negedge pcd_clk) begin : compare_outputs
        event_t ev;
        if (rx_byte_valid) begin
            if (exp_q.size() == 0 || exp_q[0].is_end) begin
                other_count++;
                $display("[%0t ns] a byte came out where none was expected", $time);
            end else begin
                ev = exp_q.pop_front();
                check_byte(rx_byte, ev.data, "rx_byte");
                check_parity(rx_parity_err, ev.par_err);
            end
        end
        if (rx_frame_end) begin
            if (exp_q.size() == 0 || !exp_q[0].is_end) begin
                other_count++;
                $display("[%0t ns] a frame end came out where none was expected", $time);
            end else begin
                ev = exp_q.pop_front();
                check_residual(rx_last_bits, ev.residual);
                if (ev.residual != 4'd0) begin
                    check_byte(rx_byte, ev.data, "partial byte");
                end
            end
        end
        if (rx_seq_err) begin
            seen_seq_err++;
        end
    end

    // the limit grows with every frame that is scheduled
    always @(posedge pcd_clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout after %0d cycles with %0d events still due", cycle_cnt,
                     exp_q.size());
            $display("Test failed");
            $finish;
        end
    end

    // ----------------------------------------
    // pause encoder
    // ----------------------------------------

    // n rising edges on, then the inputs move a little after the edge
    task automatic advance(input int n);
        repeat (n) begin
            @(posedge pcd_clk);
        end
        #(DRIVE_DELAY);
    endtask

    task automatic pause_at(input int start);
        int len;
        len = 28 + int'($urandom % 13);
        advance(start - cur_cycle);
        pcd_pause_n = 1'b0;
        advance(len);
        pcd_pause_n = 1'b1;
        cur_cycle = start + len;
    endtask

    task automatic clear_frame();
        tx_bits.delete();
    endtask

    // LSB first, then odd parity unless it is to be broken on purpose
    task automatic add_byte(input logic [7:0] value, input logic flip);
        for (int j = 0; j < 8; j++) begin
            tx_bits.push_back(value[j]);
        end
        tx_bits.push_back(~(^value) ^ flip);
    endtask

    task automatic add_bits(input logic [7:0] value, input int n);
        for (int j = 0; j < n; j++) begin
            tx_bits.push_back(value[j]);
        end
    endtask

    function automatic int frame_cycles(input int nbits);
        return LEAD + (nbits + 3) * BIT_CYCLES + IDLE;
    endfunction

    // SOC Z, one sequence per bit, then logic 0 and Y to close the frame
    task automatic send_frame();
        bit prev_one;
        int n;
        n = tx_bits.size();
        cycle_limit += frame_cycles(n);
        expect_frame();
        cur_cycle = 0;
        pause_at(LEAD);
        // the SOC counts as a 0, so a leading 0 is another Z
        prev_one = 1'b0;
        for (int i = 0; i < n; i++) begin
            if (tx_bits[i]) begin
                pause_at(LEAD + (i + 1) * BIT_CYCLES + HALF_BIT_TICKS);
            end else if (!prev_one) begin
                pause_at(LEAD + (i + 1) * BIT_CYCLES);
            end
            prev_one = tx_bits[i];
        end
        // a 0 after a 1 is a Y with no pause
        if (!prev_one) begin
            pause_at(LEAD + (n + 1) * BIT_CYCLES);
        end
        advance(frame_cycles(n) - cur_cycle);
    endtask

    // an SOC alone times out as an empty frame, the late pause is then a sequence error
    task automatic send_bad_interval();
        cycle_limit += LEAD + 5 * HALF_BIT_TICKS + 40 + IDLE;
        clear_frame();
        expect_frame();
        exp_seq_err++;
        cur_cycle = 0;
        pause_at(LEAD);
        pause_at(LEAD + 5 * HALF_BIT_TICKS);
        advance(LEAD + 5 * HALF_BIT_TICKS + 40 + IDLE - cur_cycle);
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------

    initial begin : main
        logic [7:0] rb;
        void'($urandom(RAND_SEED));
        pcd_rst_n   = 1'b0;
        pcd_pause_n = 1'b1;
        repeat (RESET_CYCLES) @(posedge pcd_clk);
        #(DRIVE_DELAY);
        pcd_rst_n = 1'b1;
        advance(20);

        // four random bytes with good parity
        clear_frame();
        repeat (4) begin
            rb = 8'($urandom);
            add_byte(rb, 1'b0);
        end
        send_frame();

        // 7-bit short frame as used for REQA
        clear_frame();
        add_bits(8'h26, 7);
        send_frame();

        // only the middle byte carries a broken parity bit
        clear_frame();
        add_byte(8'h5a, 1'b0);
        add_byte(8'hc3, 1'b1);
        add_byte(8'h0f, 1'b0);
        send_frame();

        // five half bits between pauses, then a clean frame
        send_bad_interval();
        clear_frame();
        repeat (2) begin
            rb = 8'($urandom);
            add_byte(rb, 1'b0);
        end
        send_frame();

        // frames ending in 1 and in 0, whole bytes and short ones
        clear_frame();
        add_byte(8'h00, 1'b0);
        send_frame();
        clear_frame();
        add_byte(8'h01, 1'b0);
        send_frame();
        clear_frame();
        add_bits(8'h05, 3);
        send_frame();
        clear_frame();
        add_bits(8'h06, 4);
        send_frame();

        // the cycle counter catches a DUT that never delivers the remaining events
        while (exp_q.size() != 0) begin
            @(posedge pcd_clk);
        end
        advance(20);

        if (seen_seq_err != exp_seq_err) begin
            other_count++;
            $display("saw %0d sequence errors but %0d were expected", seen_seq_err, exp_seq_err);
        end
        if (dut0.sequence_decode0.checker0.fail_count != 0) begin
            other_count += dut0.sequence_decode0.checker0.fail_count;
            $display("the decoder checker reported %0d assertion failures",
                     dut0.sequence_decode0.checker0.fail_count);
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== hw/clk_recovery.sv ====
// clk_recovery: synchronizes the reader pause and derives the card tick enable that halts during pauses
module clk_recovery #(
    parameter int STOP_AFTER_TICKS  = 4,
    parameter int START_AFTER_TICKS = 10
) (
    input  logic pcd_clk,
    input  logic pcd_rst_n,
    input  logic pcd_pause_n,
    output logic picc_tick,
    output logic pause_end
);

    // the down counters reach 1 one cycle before the tick has to change
    localparam int STOP_LOAD  = (STOP_AFTER_TICKS > 1) ? STOP_AFTER_TICKS - 1 : 0;
    localparam int START_LOAD = (START_AFTER_TICKS > 1) ? START_AFTER_TICKS - 1 : 0;
    localparam int DLY_MAX    = (STOP_LOAD > START_LOAD) ? STOP_LOAD : START_LOAD;
    localparam int DLY_W      = (DLY_MAX < 1) ? 1 : $clog2(DLY_MAX + 1);

    logic             sync1_q;
    logic             sync2_q;
    logic             prev_q;
    logic             pause_fall;
    logic             pause_rise;
    logic [DLY_W-1:0] stop_cnt_q;
    logic [DLY_W-1:0] start_cnt_q;
    logic             tick_en_q;

    // ----------------------------------------
    // pause synchronizer and edge detect
    // ----------------------------------------

    // pause_n is idle high, so the flops come out of reset high and no edge is seen
    always_ff @(posedge pcd_clk or negedge pcd_rst_n) begin
        if (!pcd_rst_n) begin
            sync1_q <= 1'b1;
            sync2_q <= 1'b1;
            prev_q  <= 1'b1;
        end else begin
            sync1_q <= pcd_pause_n;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
        end
    end

    assign pause_fall = prev_q & ~sync2_q;
    assign pause_rise = ~prev_q & sync2_q;

    // ----------------------------------------
    // tick enable
    // ----------------------------------------

    // the analogue front end loses the carrier shortly after the pause starts
    // and regains it some time after the pause ends, modelled here as two delays
    // a stop delay of 0 gives a card clock that never halts
    always_ff @(posedge pcd_clk or negedge pcd_rst_n) begin
        if (!pcd_rst_n) begin
            stop_cnt_q  <= '0;
            start_cnt_q <= '0;
            tick_en_q   <= 1'b1;
        end else if (pause_fall) begin
            stop_cnt_q  <= DLY_W'(STOP_LOAD);
            start_cnt_q <= '0;
            if (STOP_AFTER_TICKS == 1) begin
                tick_en_q <= 1'b0;
            end
        end else if (pause_rise) begin
            // a pause shorter than the stop delay never halts the clock at all
            stop_cnt_q  <= '0;
            start_cnt_q <= DLY_W'(START_LOAD);
            // with a start delay of 0 or 1 the clock is back on the next cycle
            if (START_AFTER_TICKS <= 1) begin
                tick_en_q <= 1'b1;
            end
        end else begin
            if (stop_cnt_q == DLY_W'(1)) begin
                tick_en_q <= 1'b0;
            end
            if (start_cnt_q == DLY_W'(1)) begin
                tick_en_q <= 1'b1;
            end
            if (stop_cnt_q != '0) begin
                stop_cnt_q <= stop_cnt_q - 1'b1;
            end
            if (start_cnt_q != '0) begin
                start_cnt_q <= start_cnt_q - 1'b1;
            end
        end
    end

    assign picc_tick = tick_en_q;

    // the decoder measures from one pause end to the next
    assign pause_end = pause_rise;

endmodule

// ==== hw/frame_assembler.sv ====
// frame_assembler: packs decoded bits into bytes with odd parity and reports the end of each frame
module frame_assembler (
    input  logic       pcd_clk,
    input  logic       pcd_rst_n,
    bit_if.asm         bits,
    output logic [7:0] rx_byte,
    output logic       rx_byte_valid,
    output logic       rx_parity_err,
    output logic       rx_frame_end,
    output logic [3:0] rx_last_bits,
    output logic       rx_seq_err
);

    // position 8 is the parity bit that closes a byte
    logic [3:0] bit_pos_q;
    logic [7:0] shift_q;
    logic       par_q;
    logic [7:0] rx_byte_q;
    logic       rx_byte_valid_q;
    logic       rx_parity_err_q;
    logic       rx_frame_end_q;
    logic [3:0] rx_last_bits_q;
    logic       rx_seq_err_q;

    // ----------------------------------------
    // byte shifter
    // ----------------------------------------

    // data arrives least significant first, so each bit enters at the top and moves down
    always_ff @(posedge pcd_clk) begin
        if (bits.bit_valid && bit_pos_q != 4'd8) begin
            shift_q <= {bits.bit_value, shift_q[7:1]};
        end
    end

    // ----------------------------------------
    // position, parity and strobes
    // ----------------------------------------

    always_ff @(posedge pcd_clk or negedge pcd_rst_n) begin
        if (!pcd_rst_n) begin
            bit_pos_q       <= '0;
            par_q           <= 1'b0;
            rx_byte_valid_q <= 1'b0;
            rx_parity_err_q <= 1'b0;
            rx_frame_end_q  <= 1'b0;
            rx_last_bits_q  <= '0;
            rx_seq_err_q    <= 1'b0;
        end else begin
            rx_byte_valid_q <= 1'b0;
            rx_parity_err_q <= 1'b0;
            rx_frame_end_q  <= 1'b0;
            rx_seq_err_q    <= bits.seq_err;

            if (bits.soc || bits.seq_err) begin
                // a new frame or an abandoned one both start counting again
                bit_pos_q <= '0;
                par_q     <= 1'b0;
            end else if (bits.eoc) begin
                // a short frame leaves its bit count behind, a whole byte leaves 0
                rx_frame_end_q <= 1'b1;
                rx_last_bits_q <= bit_pos_q;
                bit_pos_q      <= '0;
                par_q          <= 1'b0;
            end else if (bits.bit_valid) begin
                if (bit_pos_q == 4'd8) begin
                    // odd parity means data and parity together hold an odd number of ones
                    rx_byte_valid_q <= 1'b1;
                    rx_parity_err_q <= ~(par_q ^ bits.bit_value);
                    bit_pos_q       <= '0;
                    par_q           <= 1'b0;
                end else begin
                    bit_pos_q <= bit_pos_q + 1'b1;
                    par_q     <= par_q ^ bits.bit_value;
                end
            end
        end
    end

    // the byte register follows either a completed byte or the partial one at frame end
    always_ff @(posedge pcd_clk) begin
        if (bits.eoc && !bits.soc && !bits.seq_err) begin
            // fewer than 8 bits sit at the top of the shifter, move them down to bit 0
            rx_byte_q <= shift_q >> (4'd8 - bit_pos_q);
        end else if (bits.bit_valid && bit_pos_q == 4'd8 && !bits.soc && !bits.seq_err) begin
            rx_byte_q <= shift_q;
        end
    end

    assign rx_byte       = rx_byte_q;
    assign rx_byte_valid = rx_byte_valid_q;
    assign rx_parity_err = rx_parity_err_q;
    assign rx_frame_end  = rx_frame_end_q;
    assign rx_last_bits  = rx_last_bits_q;
    assign rx_seq_err    = rx_seq_err_q;

endmodule

// ==== hw/picc_rx.sv ====
// picc_rx: ISO/IEC 14443A card receive front end from reader pause to bytes
module picc_rx #(
    parameter int STOP_AFTER_TICKS  = 4,
    parameter int START_AFTER_TICKS = 10
) (
    input  logic       pcd_clk,
    input  logic       pcd_rst_n,
    input  logic       pcd_pause_n,
    output logic [7:0] rx_byte,
    output logic       rx_byte_valid,
    output logic       rx_parity_err,
    output logic       rx_frame_end,
    output logic [3:0] rx_last_bits,
    output logic       rx_seq_err
);

    logic picc_tick;
    logic pause_end;

    // decoded bits between the sequence decoder and the assembler
    bit_if bit_link ();

    // card clock recovery, the tick enable stands in for the halting card clock
    clk_recovery #(
        .STOP_AFTER_TICKS  (STOP_AFTER_TICKS),
        .START_AFTER_TICKS (START_AFTER_TICKS)
    ) clk_recovery0 (
        .pcd_clk     (pcd_clk),
        .pcd_rst_n   (pcd_rst_n),
        .pcd_pause_n (pcd_pause_n),
        .picc_tick   (picc_tick),
        .pause_end   (pause_end)
    );

    sequence_decode sequence_decode0 (
        .pcd_clk   (pcd_clk),
        .pcd_rst_n (pcd_rst_n),
        .picc_tick (picc_tick),
        .pause_end (pause_end),
        .bits      (bit_link.dec)
    );

    frame_assembler frame_assembler0 (
        .pcd_clk       (pcd_clk),
        .pcd_rst_n     (pcd_rst_n),
        .bits          (bit_link.asm),
        .rx_byte       (rx_byte),
        .rx_byte_valid (rx_byte_valid),
        .rx_parity_err (rx_parity_err),
        .rx_frame_end  (rx_frame_end),
        .rx_last_bits  (rx_last_bits),
        .rx_seq_err    (rx_seq_err)
    );

endmodule

// ==== hw/picc_rx_pkg.sv ====
// picc_rx shared definitions: Modified Miller sequence type, interval windows and the bit link
package picc_rx_pkg;

    // ----------------------------------------
    // sequence type
    // ----------------------------------------

    // X has its pause half way through the bit, Z at the start of the bit and Y has none
    typedef enum logic [1:0] {
        seq_x    = 2'd0,
        seq_y    = 2'd1,
        seq_z    = 2'd2,
        seq_none = 2'd3
    } seq_t;

    // ----------------------------------------
    // timing
    // ----------------------------------------

    // carrier cycles in half a bit period (fc / 64 per half bit at 106 kbit/s)
    localparam int HALF_BIT_TICKS = 64;

    // ticks lost per pause while the recovered clock is halted
    // a negative figure allows for a clock that never stops plus some edge jitter
    localparam int DROP_MIN = -3;
    localparam int DROP_MAX = 58;

    // width of the tick counter between pause ends
    localparam int CNT_W = 9;

    // an interval of n half bits is accepted between n*64 - DROP_MAX and n*64 - DROP_MIN
    localparam logic [CNT_W-1:0] WIN2_LO = CNT_W'(2 * HALF_BIT_TICKS - DROP_MAX);
    localparam logic [CNT_W-1:0] WIN2_HI = CNT_W'(2 * HALF_BIT_TICKS - DROP_MIN);
    localparam logic [CNT_W-1:0] WIN3_LO = CNT_W'(3 * HALF_BIT_TICKS - DROP_MAX);
    localparam logic [CNT_W-1:0] WIN3_HI = CNT_W'(3 * HALF_BIT_TICKS - DROP_MIN);
    localparam logic [CNT_W-1:0] WIN4_LO = CNT_W'(4 * HALF_BIT_TICKS - DROP_MAX);
    localparam logic [CNT_W-1:0] WIN4_HI = CNT_W'(4 * HALF_BIT_TICKS - DROP_MIN);

    // once the count goes past the widest window the frame is over
    localparam logic [CNT_W-1:0] EOC_TICKS = WIN4_HI;

    // a pause ending within five half bits of the previous one is still part of that frame,
    // so it cannot open a new one
    localparam logic [CNT_W-1:0] GUARD_TICKS = CNT_W'(5 * HALF_BIT_TICKS - DROP_MIN);

endpackage

// decoded bit stream from the sequence decoder to the frame assembler
interface bit_if;

    // one-cycle strobe, bit_value is only meaningful alongside it
    logic bit_valid;
    logic bit_value;

    // start and end of communication, one cycle each
    logic soc;
    logic eoc;

    // interval outside every window, the frame is abandoned
    logic seq_err;

    modport dec (output bit_valid, bit_value, soc, eoc, seq_err);
    modport asm (input bit_valid, bit_value, soc, eoc, seq_err);

endinterface

// ==== hw/sequence_decode.sv ====
// sequence_decode: classifies pause-to-pause intervals into Modified Miller sequences and bits
module sequence_decode (
    input  logic   pcd_clk,
    input  logic   pcd_rst_n,
    input  logic   picc_tick,
    input  logic   pause_end,
    bit_if.dec     bits
);

    import picc_rx_pkg::*;

    // the state records which sequence carried the last pause
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_AFTER_Z,
        ST_AFTER_X
    } state_t;

    state_t           state_q;
    logic [CNT_W-1:0] cnt_q;
    logic [2:0]       half_bits;
    seq_t             seq_first;
    seq_t             seq_last;
    logic             timeout;
    logic             held_q;
    logic             held_val_q;
    logic             pend_q;
    logic             pend_val_q;
    logic             eoc_pend_q;
    logic             bit_valid_q;
    logic             bit_value_q;
    logic             soc_q;
    logic             eoc_q;
    logic             seq_err_q;

    // X carries a 1, Y and Z both carry a 0
    function automatic logic seq_bit(seq_t s);
        return s == seq_x;
    endfunction

    // ----------------------------------------
    // interval classification
    // ----------------------------------------

    // 0 means the count fits none of the windows
    always_comb begin
        half_bits = 3'd0;
        if (cnt_q >= WIN2_LO && cnt_q <= WIN2_HI) begin
            half_bits = 3'd2;
        end else if (cnt_q >= WIN3_LO && cnt_q <= WIN3_HI) begin
            half_bits = 3'd3;
        end else if (cnt_q >= WIN4_LO && cnt_q <= WIN4_HI) begin
            half_bits = 3'd4;
        end
    end

    // a Y never has a pause of its own, so it only shows up as the first of two sequences
    // Z then Y cannot happen inside a frame since a 0 after a 0 is always sent as Z
    always_comb begin
        seq_first = seq_none;
        seq_last  = seq_none;
        case (state_q)
            ST_AFTER_Z: begin
                if (half_bits == 3'd2) begin
                    seq_last = seq_z;
                end else if (half_bits == 3'd3) begin
                    seq_last = seq_x;
                end
            end
            ST_AFTER_X: begin
                if (half_bits == 3'd2) begin
                    seq_last = seq_x;
                end else if (half_bits == 3'd3) begin
                    seq_first = seq_y;
                    seq_last  = seq_z;
                end else if (half_bits == 3'd4) begin
                    seq_first = seq_y;
                    seq_last  = seq_x;
                end
            end
            default: begin
            end
        endcase
    end

    // the count passes the widest window with no pause, so the frame has ended in a Y
    assign timeout = picc_tick && (cnt_q == EOC_TICKS) && (state_q != ST_IDLE);

    // ----------------------------------------
    // decoder
    // ----------------------------------------

    always_ff @(posedge pcd_clk or negedge pcd_rst_n) begin
        if (!pcd_rst_n) begin
            state_q     <= ST_IDLE;
            // start saturated so the very first pause is taken as a start of frame
            cnt_q       <= '1;
            held_q      <= 1'b0;
            pend_q      <= 1'b0;
            eoc_pend_q  <= 1'b0;
            bit_valid_q <= 1'b0;
            soc_q       <= 1'b0;
            eoc_q       <= 1'b0;
            seq_err_q   <= 1'b0;
        end else begin
            bit_valid_q <= 1'b0;
            soc_q       <= 1'b0;
            seq_err_q   <= 1'b0;
            pend_q      <= 1'b0;
            eoc_pend_q  <= 1'b0;
            // eoc always trails the released bit by one cycle
            eoc_q       <= eoc_pend_q;

            // ticks since the last pause end, held at full scale while idle
            if (pause_end) begin
                cnt_q <= '0;
            end else if (picc_tick && cnt_q != '1) begin
                cnt_q <= cnt_q + 1'b1;
            end

            // second bit of a two-sequence interval
            if (pend_q) begin
                bit_valid_q <= 1'b1;
                bit_value_q <= pend_val_q;
            end

            if (pause_end) begin
                if (state_q == ST_IDLE) begin
                    // the first pause of a frame is the start of communication Z
                    if (cnt_q > GUARD_TICKS) begin
                        soc_q   <= 1'b1;
                        state_q <= ST_AFTER_Z;
                    end else begin
                        seq_err_q <= 1'b1;
                    end
                    held_q <= 1'b0;
                end else if (seq_last == seq_none) begin
                    seq_err_q <= 1'b1;
                    state_q   <= ST_IDLE;
                    held_q    <= 1'b0;
                end else begin
                    // the bit held from the last interval goes out first
                    if (held_q) begin
                        bit_valid_q <= 1'b1;
                        bit_value_q <= held_val_q;
                        if (seq_first != seq_none) begin
                            pend_q     <= 1'b1;
                            pend_val_q <= seq_bit(seq_first);
                        end
                    end else if (seq_first != seq_none) begin
                        bit_valid_q <= 1'b1;
                        bit_value_q <= seq_bit(seq_first);
                    end
                    // the newest bit waits, it may turn out to be the end of communication 0
                    held_q     <= 1'b1;
                    held_val_q <= seq_bit(seq_last);
                    state_q    <= (seq_last == seq_x) ? ST_AFTER_X : ST_AFTER_Z;
                end
            end else if (timeout) begin
                // after X the frame ended 1, Y and the held 1 is real data
                // after Z the held 0 was the end of communication marker itself
                if (state_q == ST_AFTER_X && held_q) begin
                    bit_valid_q <= 1'b1;
                    bit_value_q <= held_val_q;
                end
                eoc_pend_q <= 1'b1;
                held_q     <= 1'b0;
                state_q    <= ST_IDLE;
            end
        end
    end

    assign bits.bit_valid = bit_valid_q;
    assign bits.bit_value = bit_value_q;
    assign bits.soc       = soc_q;
    assign bits.eoc       = eoc_q;
    assign bits.seq_err   = seq_err_q;

endmodule

// ==== picc_rx.f ====
hw/picc_rx_pkg.sv
hw/clk_recovery.sv
hw/sequence_decode.sv
hw/frame_assembler.sv
hw/picc_rx.sv
dv/picc_rx_checker.sv
dv/picc_rx_tb.sv
